// ==== common/hpdcache_pkg.sv ====
package hpdcache_pkg;

    // Base geometry
    localparam int HPDCACHE_ADDR_WIDTH = 32;
    localparam int HPDCACHE_WORD_WIDTH = 32;
    localparam int HPDCACHE_CL_WORDS   = 4;
    localparam int HPDCACHE_SETS       = 16;
    localparam int HPDCACHE_SID_WIDTH  = 2;
    localparam int HPDCACHE_TID_WIDTH  = 4;

    // Derived widths
    localparam int HPDCACHE_BYTE_OFFSET_WIDTH = $clog2(HPDCACHE_WORD_WIDTH / 8);
    localparam int HPDCACHE_WORD_IDX_WIDTH    = $clog2(HPDCACHE_CL_WORDS);
    localparam int HPDCACHE_OFFSET_WIDTH      = HPDCACHE_BYTE_OFFSET_WIDTH +
                                                HPDCACHE_WORD_IDX_WIDTH;
    localparam int HPDCACHE_SET_WIDTH         = $clog2(HPDCACHE_SETS);
    localparam int HPDCACHE_TAG_WIDTH         = HPDCACHE_ADDR_WIDTH - HPDCACHE_SET_WIDTH -
                                                HPDCACHE_OFFSET_WIDTH;
    localparam int HPDCACHE_NLINE_WIDTH       = HPDCACHE_TAG_WIDTH + HPDCACHE_SET_WIDTH;
    localparam int HPDCACHE_CL_WIDTH          = HPDCACHE_WORD_WIDTH * HPDCACHE_CL_WORDS;
    localparam int HPDCACHE_WADDR_WIDTH       = HPDCACHE_ADDR_WIDTH - HPDCACHE_BYTE_OFFSET_WIDTH;

    typedef logic [HPDCACHE_ADDR_WIDTH-1:0]     hpdcache_addr_t;
    typedef logic [HPDCACHE_WORD_WIDTH-1:0]     hpdcache_word_t;
    typedef logic [HPDCACHE_SET_WIDTH-1:0]      hpdcache_set_t;
    typedef logic [HPDCACHE_WORD_IDX_WIDTH-1:0] hpdcache_word_idx_t;
    typedef logic [HPDCACHE_TAG_WIDTH-1:0]      hpdcache_tag_t;
    typedef logic [HPDCACHE_NLINE_WIDTH-1:0]    hpdcache_nline_t;
    typedef logic [HPDCACHE_CL_WIDTH-1:0]       hpdcache_line_t;
    typedef logic [HPDCACHE_SID_WIDTH-1:0]      hpdcache_sid_t;
    typedef logic [HPDCACHE_TID_WIDTH-1:0]      hpdcache_tid_t;

    typedef struct packed {
        logic           wr;
        hpdcache_addr_t addr;
        hpdcache_word_t wdata;
        hpdcache_sid_t  sid;
        hpdcache_tid_t  tid;
    } hpdcache_req_t;

    // Writes return zero read data
    typedef struct packed {
        hpdcache_word_t rdata;
        hpdcache_sid_t  sid;
        hpdcache_tid_t  tid;
    } hpdcache_rsp_t;

    // Line address (zero-extended) on the miss read port,
    // word address with write data on the write port
    typedef struct packed {
        logic [HPDCACHE_WADDR_WIDTH-1:0] addr;
        hpdcache_word_t                  wdata;
    } hpdcache_mem_req_t;

    typedef struct packed {
        hpdcache_line_t data;
    } hpdcache_mem_rsp_t;

    typedef enum logic [2:0] {
        IDLE,
        LOOKUP,
        COMPARE,
        MISS_WAIT,
        WRITE_MEM,
        RESPOND
    } hpdcache_ctrl_state_e;

endpackage

// ==== ctrl/hpdcache_dir_data.sv ====
`timescale 1ns/1ps

module hpdcache_dir_data
    import hpdcache_pkg::*;
(
    input  logic               clk_i,
    input  logic               rst_n_i,

    input  hpdcache_set_t      rd_set_i,
    output logic               rd_valid_o,
    output hpdcache_tag_t      rd_tag_o,
    output hpdcache_line_t     rd_line_o,

    input  logic               wr_word_i,
    input  hpdcache_set_t      wr_set_i,
    input  hpdcache_word_idx_t wr_word_idx_i,
    input  hpdcache_word_t     wr_data_i,

    input  logic               refill_i,
    input  hpdcache_nline_t    refill_nline_i,
    input  hpdcache_line_t     refill_line_i
);

    logic [HPDCACHE_SETS-1:0] valid_q;
    hpdcache_tag_t            tag_mem  [HPDCACHE_SETS];
    hpdcache_line_t           line_mem [HPDCACHE_SETS];

    hpdcache_set_t            refill_set;
    hpdcache_tag_t            refill_tag;

    assign refill_set = refill_nline_i[HPDCACHE_SET_WIDTH-1:0];
    assign refill_tag = refill_nline_i[HPDCACHE_NLINE_WIDTH-1 -: HPDCACHE_TAG_WIDTH];

    // Directory valid bits
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            valid_q    <= '0;
            rd_valid_o <= 1'b0;
        end else begin
            if (refill_i) begin
                valid_q[refill_set] <= 1'b1;
            end
            rd_valid_o <= valid_q[rd_set_i];
        end
    end

    // Tag and line storage
    always_ff @(posedge clk_i) begin
        if (refill_i) begin
            tag_mem[refill_set]  <= refill_tag;
            line_mem[refill_set] <= refill_line_i;
        end else if (wr_word_i) begin
            line_mem[wr_set_i][wr_word_idx_i*HPDCACHE_WORD_WIDTH +: HPDCACHE_WORD_WIDTH]
                <= wr_data_i;
        end
        rd_tag_o  <= tag_mem[rd_set_i];
        rd_line_o <= line_mem[rd_set_i];
    end

endmodule

// ==== ctrl/hpdcache_ctrl.sv ====
`timescale 1ns/1ps

module hpdcache_ctrl
    import hpdcache_pkg::*;
(
    input  logic              clk_i,
    input  logic              rst_n_i,

    input  logic              req_valid_i,
    output logic              req_ready_o,
    input  hpdcache_req_t     req_i,

    output logic              rsp_valid_o,
    output hpdcache_rsp_t     rsp_o,

    output logic              miss_start_o,
    output hpdcache_nline_t   miss_nline_o,
    input  logic              refill_done_i,

    input  logic              refill_i,
    input  hpdcache_nline_t   refill_nline_i,
    input  hpdcache_line_t    refill_line_i,

    output logic              mem_write_valid_o,
    input  logic              mem_write_ready_i,
    output hpdcache_mem_req_t mem_write_o,

    output logic              evt_read_miss_o,
    output logic              evt_write_miss_o
);

    hpdcache_ctrl_state_e state_q;
    hpdcache_ctrl_state_e state_d;

    hpdcache_req_t        req_q;
    hpdcache_word_t       rdata_q;

    hpdcache_set_t        req_set;
    hpdcache_tag_t        req_tag;
    hpdcache_word_idx_t   req_word_idx;

    logic                 rd_valid;
    hpdcache_tag_t        rd_tag;
    hpdcache_line_t       rd_line;
    hpdcache_word_t       hit_word;
    logic                 hit;
    logic                 wr_word;

    assign req_set      = req_q.addr[HPDCACHE_OFFSET_WIDTH +: HPDCACHE_SET_WIDTH];
    assign req_tag      = req_q.addr[HPDCACHE_ADDR_WIDTH-1 -: HPDCACHE_TAG_WIDTH];
    assign req_word_idx = req_q.addr[HPDCACHE_BYTE_OFFSET_WIDTH +: HPDCACHE_WORD_IDX_WIDTH];

    // Array output is valid in COMPARE, one cycle after LOOKUP
    assign hit      = rd_valid && (rd_tag == req_tag);
    assign hit_word = rd_line[req_word_idx*HPDCACHE_WORD_WIDTH +: HPDCACHE_WORD_WIDTH];
    assign wr_word  = (state_q == COMPARE) && req_q.wr && hit;

    hpdcache_dir_data dir_data0 (
        .clk_i          (clk_i),
        .rst_n_i        (rst_n_i),
        .rd_set_i       (req_set),
        .rd_valid_o     (rd_valid),
        .rd_tag_o       (rd_tag),
        .rd_line_o      (rd_line),
        .wr_word_i      (wr_word),
        .wr_set_i       (req_set),
        .wr_word_idx_i  (req_word_idx),
        .wr_data_i      (req_q.wdata),
        .refill_i       (refill_i),
        .refill_nline_i (refill_nline_i),
        .refill_line_i  (refill_line_i)
    );

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (req_valid_i) begin
                    state_d = LOOKUP;
                end
            end
            LOOKUP: begin
                state_d = COMPARE;
            end
            COMPARE: begin
                if (req_q.wr) begin
                    state_d = WRITE_MEM;
                end else if (hit) begin
                    state_d = RESPOND;
                end else begin
                    state_d = MISS_WAIT;
                end
            end
            MISS_WAIT: begin
                // Replay the lookup on the refilled line
                if (refill_done_i) begin
                    state_d = LOOKUP;
                end
            end
            WRITE_MEM: begin
                if (mem_write_ready_i) begin
                    state_d = RESPOND;
                end
            end
            RESPOND: begin
                state_d = IDLE;
            end
            default: begin
                state_d = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    always_ff @(posedge clk_i) begin
        if (state_q == IDLE && req_valid_i) begin
            req_q <= req_i;
        end
        if (state_q == COMPARE) begin
            rdata_q <= req_q.wr ? '0 : hit_word;
        end
    end

    assign req_ready_o = (state_q == IDLE);

    assign rsp_valid_o = (state_q == RESPOND);
    assign rsp_o.rdata = rdata_q;
    assign rsp_o.sid   = req_q.sid;
    assign rsp_o.tid   = req_q.tid;

    assign miss_start_o = (state_q == COMPARE) && !req_q.wr && !hit;
    assign miss_nline_o = req_q.addr[HPDCACHE_ADDR_WIDTH-1 -: HPDCACHE_NLINE_WIDTH];

    // Every write goes to memory, hit or miss
    assign mem_write_valid_o = (state_q == WRITE_MEM);
    assign mem_write_o.addr  = req_q.addr[HPDCACHE_ADDR_WIDTH-1:HPDCACHE_BYTE_OFFSET_WIDTH];
    assign mem_write_o.wdata = req_q.wdata;

    assign evt_read_miss_o  = miss_start_o;
    assign evt_write_miss_o = (state_q == COMPARE) && req_q.wr && !hit;

endmodule

// ==== logic/hpdcache_req_arbiter.sv ====
`timescale 1ns/1ps

module hpdcache_req_arbiter
    import hpdcache_pkg::*;
#(
    parameter int NREQUESTERS = 2
) (
    input  logic                            clk_i,
    input  logic                            rst_n_i,
    input  logic          [NREQUESTERS-1:0] req_valid_i,
    input  hpdcache_req_t [NREQUESTERS-1:0] req_i,
    input  logic                            ready_i,
    output logic          [NREQUESTERS-1:0] gnt_o,
    output logic                            arb_valid_o,
    output hpdcache_req_t                   arb_req_o
);

    logic [NREQUESTERS-1:0] prio_gnt;
    logic [NREQUESTERS-1:0] gnt_q;
    logic                   hold_q;

    // Lowest index wins
    always_comb begin : prio_sel
        logic found;
        found    = 1'b0;
        prio_gnt = '0;
        for (int i = 0; i < NREQUESTERS; i++) begin
            if (req_valid_i[i] && !found) begin
                prio_gnt[i] = 1'b1;
                found       = 1'b1;
            end
        end
    end

    // A stalled grant stays put until the controller takes it
    assign gnt_o       = hold_q ? (gnt_q & req_valid_i) : prio_gnt;
    assign arb_valid_o = |gnt_o;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            gnt_q  <= '0;
            hold_q <= 1'b0;
        end else begin
            gnt_q  <= gnt_o;
            hold_q <= arb_valid_o && !ready_i;
        end
    end

    // One-hot request mux
    always_comb begin
        arb_req_o = '0;
        for (int i = 0; i < NREQUESTERS; i++) begin
            if (gnt_o[i]) begin
                arb_req_o = arb_req_o | req_i[i];
            end
        end
    end

endmodule

// ==== logic/hpdcache_miss_handler.sv ====
`timescale 1ns/1ps

module hpdcache_miss_handler
    import hpdcache_pkg::*;
(
    input  logic              clk_i,
    input  logic              rst_n_i,

    input  logic              start_i,
    input  hpdcache_nline_t   nline_i,

    output logic              mem_req_valid_o,
    input  logic              mem_req_ready_i,
    output hpdcache_mem_req_t mem_req_o,

    input  logic              mem_resp_valid_i,
    output logic              mem_resp_ready_o,
    input  hpdcache_mem_rsp_t mem_resp_i,

    output logic              refill_o,
    output hpdcache_nline_t   refill_nline_o,
    output hpdcache_line_t    refill_line_o,

    output logic              done_o
);

    // Idle, then request, wait and refill
    typedef enum logic [1:0] {
        MH_IDLE,
        MH_REQ,
        MH_WAIT,
        MH_REFILL
    } miss_state_e;

    miss_state_e     state_q;
    hpdcache_nline_t nline_q;
    hpdcache_line_t  line_q;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q <= MH_IDLE;
        end else begin
            case (state_q)
                MH_IDLE: begin
                    if (start_i) begin
                        state_q <= MH_REQ;
                    end
                end
                MH_REQ: begin
                    if (mem_req_ready_i) begin
                        state_q <= MH_WAIT;
                    end
                end
                MH_WAIT: begin
                    if (mem_resp_valid_i) begin
                        state_q <= MH_REFILL;
                    end
                end
                default: begin
                    state_q <= MH_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (state_q == MH_IDLE && start_i) begin
            nline_q <= nline_i;
        end
        if (state_q == MH_WAIT && mem_resp_valid_i) begin
            line_q <= mem_resp_i.data;
        end
    end

    assign mem_req_valid_o = (state_q == MH_REQ);
    assign mem_req_o.addr  = (HPDCACHE_WADDR_WIDTH)'(nline_q);
    assign mem_req_o.wdata = '0;

    assign mem_resp_ready_o = (state_q == MH_WAIT);

    // Single-cycle refill write, done in the same cycle
    assign refill_o       = (state_q == MH_REFILL);
    assign refill_nline_o = nline_q;
    assign refill_line_o  = line_q;
    assign done_o         = refill_o;

endmodule

// ==== logic/hpdcache.sv ====
`timescale 1ns/1ps

module hpdcache
    import hpdcache_pkg::*;
#(
    parameter int NREQUESTERS = 2
) (
    input  logic                                 clk_i,
    input  logic                                 rst_n_i,

    input  logic          [NREQUESTERS-1:0]      core_req_valid_i,
    output logic          [NREQUESTERS-1:0]      core_req_ready_o,
    input  hpdcache_req_t [NREQUESTERS-1:0]      core_req_i,

    output logic          [NREQUESTERS-1:0]      core_rsp_valid_o,
    output hpdcache_rsp_t [NREQUESTERS-1:0]      core_rsp_o,

    output logic                                 mem_req_miss_read_valid_o,
    input  logic                                 mem_req_miss_read_ready_i,
    output hpdcache_mem_req_t                    mem_req_miss_read_o,

    input  logic                                 mem_resp_miss_read_valid_i,
    output logic                                 mem_resp_miss_read_ready_o,
    input  hpdcache_mem_rsp_t                    mem_resp_miss_read_i,

    output logic                                 mem_req_write_valid_o,
    input  logic                                 mem_req_write_ready_i,
    output hpdcache_mem_req_t                    mem_req_write_o,

    output logic                                 evt_read_miss_o,
    output logic                                 evt_write_miss_o
);

    logic [NREQUESTERS-1:0] arb_gnt;
    logic                   arb_req_valid;
    logic                   arb_req_ready;
    hpdcache_req_t          arb_req;

    logic                   rsp_valid;
    hpdcache_rsp_t          rsp;

    logic                   miss_start;
    hpdcache_nline_t        miss_nline;
    logic                   refill_done;
    logic                   refill;
    hpdcache_nline_t        refill_nline;
    hpdcache_line_t         refill_line;

    hpdcache_req_arbiter #(
        .NREQUESTERS (NREQUESTERS)
    ) arbiter0 (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .req_valid_i (core_req_valid_i),
        .req_i       (core_req_i),
        .ready_i     (arb_req_ready),
        .gnt_o       (arb_gnt),
        .arb_valid_o (arb_req_valid),
        .arb_req_o   (arb_req)
    );

    // Only the granted requester sees the controller ready
    assign core_req_ready_o = arb_gnt & {NREQUESTERS{arb_req_ready}};

    always_comb begin
        for (int i = 0; i < NREQUESTERS; i++) begin
            core_rsp_valid_o[i] = rsp_valid && (rsp.sid == hpdcache_sid_t'(i));
            core_rsp_o[i]       = rsp;
        end
    end

    hpdcache_ctrl ctrl0 (
        .clk_i             (clk_i),
        .rst_n_i           (rst_n_i),
        .req_valid_i       (arb_req_valid),
        .req_ready_o       (arb_req_ready),
        .req_i             (arb_req),
        .rsp_valid_o       (rsp_valid),
        .rsp_o             (rsp),
        .miss_start_o      (miss_start),
        .miss_nline_o      (miss_nline),
        .refill_done_i     (refill_done),
        .refill_i          (refill),
        .refill_nline_i    (refill_nline),
        .refill_line_i     (refill_line),
        .mem_write_valid_o (mem_req_write_valid_o),
        .mem_write_ready_i (mem_req_write_ready_i),
        .mem_write_o       (mem_req_write_o),
        .evt_read_miss_o   (evt_read_miss_o),
        .evt_write_miss_o  (evt_write_miss_o)
    );

    hpdcache_miss_handler miss0 (
        .clk_i            (clk_i),
        .rst_n_i          (rst_n_i),
        .start_i          (miss_start),
        .nline_i          (miss_nline),
        .mem_req_valid_o  (mem_req_miss_read_valid_o),
        .mem_req_ready_i  (mem_req_miss_read_ready_i),
        .mem_req_o        (mem_req_miss_read_o),
        .mem_resp_valid_i (mem_resp_miss_read_valid_i),
        .mem_resp_ready_o (mem_resp_miss_read_ready_o),
        .mem_resp_i       (mem_resp_miss_read_i),
        .refill_o         (refill),
        .refill_nline_o   (refill_nline),
        .refill_line_o    (refill_line),
        .done_o           (refill_done)
    );

endmodule

// ==== tb/hpdcache_assert.sv ====
`timescale 1ns/1ps

module hpdcache_assert
    import hpdcache_pkg::*;
#(
    parameter int NREQUESTERS = 2
) (
    input  logic                             clk_i,
    input  logic                             rst_n_i,
    input  logic                             miss_req_valid_i,
    input  logic                             miss_req_ready_i,
    input  hpdcache_mem_req_t                miss_req_i,
    input  logic                             write_valid_i,
    input  logic                             write_ready_i,
    input  hpdcache_mem_req_t                write_i,
    input  logic          [NREQUESTERS-1:0]  rsp_valid_i,
    input  logic                             evt_read_miss_i,
    input  logic                             evt_write_miss_i,
    input  hpdcache_ctrl_state_e             ctrl_state_i
);

    int fail_cnt = 0;

    // Held requests keep their payload
    miss_req_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        miss_req_valid_i && !miss_req_ready_i |=> miss_req_valid_i && $stable(miss_req_i))
        else begin
            fail_cnt++;
            $error("miss read request dropped or changed");
        end

    write_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        write_valid_i && !write_ready_i |=> write_valid_i && $stable(write_i))
        else begin
            fail_cnt++;
            $error("memory write dropped or changed");
        end

    rsp_onehot: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        $onehot0(rsp_valid_i))
        else begin
            fail_cnt++;
            $error("more than one response valid");
        end

    // The miss handler only fetches while the controller waits for it
    miss_in_miss_wait: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        miss_req_valid_i |-> ctrl_state_i == MISS_WAIT)
        else begin
            fail_cnt++;
            $error("miss read request while the controller is not in MISS_WAIT");
        end

    read_miss_pulse: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        evt_read_miss_i |=> !evt_read_miss_i)
        else begin
            fail_cnt++;
            $error("read miss event longer than one cycle");
        end

    write_miss_pulse: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        evt_write_miss_i |=> !evt_write_miss_i)
        else begin
            fail_cnt++;
            $error("write miss event longer than one cycle");
        end

endmodule

// ==== tb/hpdcache_tb.sv ====
`timescale 1ns/1ps

module hpdcache_tb
    import hpdcache_pkg::*;
();

    localparam int NREQ           = 2;
    localparam int REQ_COUNT      = 212;
    localparam int TIMEOUT_CYCLES = REQ_COUNT * 40;

    typedef logic [HPDCACHE_WADDR_WIDTH-1:0] waddr_t;

    logic                          clk_i;
    logic                          rst_n_i;
    logic          [NREQ-1:0]      core_req_valid_i;
    logic          [NREQ-1:0]      core_req_ready_o;
    hpdcache_req_t [NREQ-1:0]      core_req_i;
    logic          [NREQ-1:0]      core_rsp_valid_o;
    hpdcache_rsp_t [NREQ-1:0]      core_rsp_o;
    logic                          mem_req_miss_read_valid_o;
    logic                          mem_req_miss_read_ready_i;
    hpdcache_mem_req_t             mem_req_miss_read_o;
    logic                          mem_resp_miss_read_valid_i;
    logic                          mem_resp_miss_read_ready_o;
    hpdcache_mem_rsp_t             mem_resp_miss_read_i;
    logic                          mem_req_write_valid_o;
    logic                          mem_req_write_ready_i;
    hpdcache_mem_req_t             mem_req_write_o;
    logic                          evt_read_miss_o;
    logic                          evt_write_miss_o;

    // Sparse memory where unwritten words follow a fill pattern
    hpdcache_word_t mem_words [waddr_t];

    string         test_name = "reset";
    int            cycle_cnt = 0;
    int            rsp_cnt = 0;
    int            read_miss_cnt = 0;
    int            write_miss_cnt = 0;
    int            acc_cycle = 0;
    int            port_acc_cycle [NREQ];
    int            last_latency = 0;
    logic [NREQ-1:0] accepted_q = '0;
    hpdcache_req_t inflight_req = '0;

    hpdcache #(
        .NREQUESTERS (NREQ)
    ) dut0 (.*);

    bind hpdcache hpdcache_assert #(
        .NREQUESTERS (NREQUESTERS)
    ) assert0 (
        .clk_i            (clk_i),
        .rst_n_i          (rst_n_i),
        .miss_req_valid_i (mem_req_miss_read_valid_o),
        .miss_req_ready_i (mem_req_miss_read_ready_i),
        .miss_req_i       (mem_req_miss_read_o),
        .write_valid_i    (mem_req_write_valid_o),
        .write_ready_i    (mem_req_write_ready_i),
        .write_i          (mem_req_write_o),
        .rsp_valid_i      (core_rsp_valid_o),
        .evt_read_miss_i  (evt_read_miss_o),
        .evt_write_miss_i (evt_write_miss_o),
        .ctrl_state_i     (ctrl0.state_q)
    );

    initial begin
        clk_i = 1'b0;
        forever #50 clk_i = ~clk_i;
    end

    function automatic hpdcache_word_t model_read(input waddr_t waddr);
        if (mem_words.exists(waddr)) begin
            return mem_words[waddr];
        end
        return (32'(waddr) * 32'h9e37_79b1) ^ 32'h6c3a_91e5;
    endfunction

    // Write-through keeps the memory model as the truth
    function automatic hpdcache_rsp_t expected_rsp(input hpdcache_req_t req);
        hpdcache_rsp_t rsp;
        rsp.rdata = req.wr ? '0 : model_read(req.addr[HPDCACHE_ADDR_WIDTH-1:2]);
        rsp.sid   = req.sid;
        rsp.tid   = req.tid;
        return rsp;
    endfunction

    function automatic hpdcache_req_t make_req(input int port, input logic wr,
                                               input hpdcache_addr_t addr,
                                               input hpdcache_word_t wdata,
                                               input hpdcache_tid_t tid);
        hpdcache_req_t req;
        req.wr    = wr;
        req.addr  = addr;
        req.wdata = wdata;
        req.sid   = hpdcache_sid_t'(port);
        req.tid   = tid;
        return req;
    endfunction

    task automatic check(input string what, input logic [63:0] expected,
                         input logic [63:0] actual);
        if (expected !== actual) begin
            $display("mismatch in %s (%s): expected %h actual %h",
                     test_name, what, expected, actual);
            $display("Simulation finished: FAIL");
            $fatal(1, "check failed");
        end
    endtask

    // Called at a falling edge and returns at the falling edge after acceptance
    task automatic present(input int port, input hpdcache_req_t req);
        core_req_i[port]       = req;
        core_req_valid_i[port] = 1'b1;
        do begin
            @(negedge clk_i);
        end while (!accepted_q[port]);
        core_req_valid_i[port] = 1'b0;
    endtask

    task automatic access(input int port, input logic wr, input hpdcache_addr_t addr,
                          input hpdcache_word_t wdata, input hpdcache_tid_t tid);
        int start;
        start = rsp_cnt;
        present(port, make_req(port, wr, addr, wdata, tid));
        while (rsp_cnt == start) begin
            @(negedge clk_i);
        end
    endtask

    always @(posedge clk_i) begin
        cycle_cnt  <= cycle_cnt + 1;
        accepted_q <= core_req_valid_i & core_req_ready_o;
        if (|core_rsp_valid_o) begin
            rsp_cnt <= rsp_cnt + 1;
        end
        if (evt_read_miss_o) begin
            read_miss_cnt <= read_miss_cnt + 1;
        end
        if (evt_write_miss_o) begin
            write_miss_cnt <= write_miss_cnt + 1;
        end
        for (int p = 0; p < NREQ; p++) begin
            if (core_req_valid_i[p] && core_req_ready_o[p]) begin
                inflight_req      <= core_req_i[p];
                acc_cycle         <= cycle_cnt;
                port_acc_cycle[p] <= cycle_cnt;
            end
        end
    end

    always @(negedge clk_i) begin : compare_responses
        hpdcache_rsp_t   exp;
        logic [NREQ-1:0] exp_valid;
        if (|core_rsp_valid_o) begin
            exp                = expected_rsp(inflight_req);
            exp_valid          = '0;
            exp_valid[exp.sid] = 1'b1;
            check("response valid", 64'(exp_valid), 64'(core_rsp_valid_o));
            check("response", 64'(exp), 64'(core_rsp_o[exp.sid]));
            last_latency = cycle_cnt - acc_cycle;
        end
    end

    initial begin : miss_read_model
        waddr_t         line_waddr;
        hpdcache_nline_t nline;
        hpdcache_line_t line;
        forever begin
            @(negedge clk_i);
            if (mem_req_miss_read_valid_o) begin
                repeat ($urandom_range(5)) @(negedge clk_i);
                line_waddr = mem_req_miss_read_o.addr;
                mem_req_miss_read_ready_i = 1'b1;
                @(negedge clk_i);
                mem_req_miss_read_ready_i = 1'b0;
                repeat ($urandom_range(5)) @(negedge clk_i);
                nline = hpdcache_nline_t'(line_waddr);
                for (int w = 0; w < HPDCACHE_CL_WORDS; w++) begin
                    line[w*HPDCACHE_WORD_WIDTH +: HPDCACHE_WORD_WIDTH] =
                        model_read({nline, 2'(w)});
                end
                mem_resp_miss_read_i.data  = line;
                mem_resp_miss_read_valid_i = 1'b1;
                while (!mem_resp_miss_read_ready_o) begin
                    @(negedge clk_i);
                end
                @(negedge clk_i);
                mem_resp_miss_read_valid_i = 1'b0;
            end
        end
    end

    initial begin : write_model
        forever begin
            @(negedge clk_i);
            if (mem_req_write_valid_o) begin
                repeat ($urandom_range(5)) @(negedge clk_i);
                // Valid is held, so the next edge takes it
                mem_words[mem_req_write_o.addr] = mem_req_write_o.wdata;
                mem_req_write_ready_i = 1'b1;
                @(negedge clk_i);
                mem_req_write_ready_i = 1'b0;
            end
        end
    end

    always @(negedge clk_i) begin
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Simulation finished: FAIL");
            $fatal(1, "timeout");
        end
    end

    always @(negedge clk_i) begin
        if (dut0.assert0.fail_cnt != 0) begin
            $display("a bound assertion failed in %s", test_name);
            $display("Simulation finished: FAIL");
            $fatal(1, "assertion failed");
        end
    end

    initial begin : stimulus
        hpdcache_addr_t a;
        int             rm;
        int             wm;
        int             start;
        void'($urandom(32'hbf84_2d31));
        rst_n_i                    = 1'b0;
        core_req_valid_i           = '0;
        core_req_i                 = '0;
        mem_req_miss_read_ready_i  = 1'b0;
        mem_resp_miss_read_valid_i = 1'b0;
        mem_resp_miss_read_i       = '0;
        mem_req_write_ready_i      = 1'b0;
        repeat (5) @(negedge clk_i);
        rst_n_i = 1'b1;
        @(negedge clk_i);

        test_name = "read_miss_then_hit";
        rm = read_miss_cnt;
        access(0, 1'b0, 32'h0000_3a54, '0, 4'h1);
        check("read miss pulses", 64'(rm + 1), 64'(read_miss_cnt));
        rm = read_miss_cnt;
        access(0, 1'b0, 32'h0000_3a54, '0, 4'h2);
        check("read miss pulses", 64'(rm), 64'(read_miss_cnt));
        check("hit latency", 64'(3), 64'(last_latency));

        test_name = "write_through";
        wm = write_miss_cnt;
        access(1, 1'b1, 32'h0000_3a58, 32'hcafe_0001, 4'h3);
        check("write miss pulses", 64'(wm), 64'(write_miss_cnt));
        rm = read_miss_cnt;
        access(0, 1'b0, 32'h0000_3a58, '0, 4'h4);
        check("read miss pulses", 64'(rm), 64'(read_miss_cnt));
        check("memory word", 64'(32'hcafe_0001), 64'(model_read(30'h0000_0e96)));

        test_name = "write_miss_no_allocate";
        wm = write_miss_cnt;
        access(0, 1'b1, 32'h0000_7c68, 32'h1234_5678, 4'h5);
        check("write miss pulses", 64'(wm + 1), 64'(write_miss_cnt));
        rm = read_miss_cnt;
        access(1, 1'b0, 32'h0000_7c68, '0, 4'h6);
        check("read miss pulses", 64'(rm + 1), 64'(read_miss_cnt));

        test_name = "conflict_eviction";
        for (int i = 0; i < 4; i++) begin
            a  = (i % 2 == 0) ? 32'h0001_0080 : 32'h0002_0084;
            rm = read_miss_cnt;
            access(i % 2, 1'b0, a, '0, hpdcache_tid_t'(i + 7));
            check("read miss pulses", 64'(rm + 1), 64'(read_miss_cnt));
        end

        test_name = "arbitration_routing";
        start = rsp_cnt;
        fork
            present(0, make_req(0, 1'b0, 32'h0000_3a54, '0, 4'hb));
            present(1, make_req(1, 1'b0, 32'h0000_7c68, '0, 4'hc));
        join
        while (rsp_cnt < start + 2) begin
            @(negedge clk_i);
        end
        check("requester 0 first", 64'(1), 64'(port_acc_cycle[0] < port_acc_cycle[1]));

        test_name = "random_mix";
        for (int i = 0; i < 200; i++) begin
            a = 32'h0000_1000 | ($urandom_range(3) << 8) | ($urandom_range(3) << 4) |
                ($urandom_range(3) << 2);
            access(int'($urandom_range(1)), 1'($urandom_range(1)), a, $urandom,
                   hpdcache_tid_t'(i));
        end

        if (dut0.assert0.fail_cnt == 0) begin
            $display("Simulation finished: PASS");
            $finish;
        end else begin
            $display("%0d bound assertion failures", dut0.assert0.fail_cnt);
            $display("Simulation finished: FAIL");
            $fatal(1, "assertions failed");
        end
    end

endmodule

// ==== sources.f ====
common/hpdcache_pkg.sv
ctrl/hpdcache_dir_data.sv
ctrl/hpdcache_ctrl.sv
logic/hpdcache_req_arbiter.sv
logic/hpdcache_miss_handler.sv
logic/hpdcache.sv
tb/hpdcache_assert.sv
tb/hpdcache_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= hpdcache_tb
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	grep -q "Simulation finished: PASS" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
